/* design/axiLitePkg.sv */
// AXI4-Lite bus widths, response codes and front-end FSM states, imported by RTL and testbench
`default_nettype none

package axiLitePkg;

  // ==============================
  // bus widths
  // ==============================

  // byte address, one full word
  localparam int axiAddrWidth = 32;
  // data bus, one full word
  localparam int axiDataWidth = 32;

  typedef logic [axiAddrWidth-1:0] axiAddr_t;
  typedef logic [axiDataWidth-1:0] axiData_t;

  // ==============================
  // responses
  // ==============================

  // bResp / rResp encoding
  typedef logic [1:0] axiResp_t;

  // only OKAY is ever returned
  localparam axiResp_t respOkay = 2'b00;

  // ==============================
  // front-end FSM
  // ==============================

  // one transaction in flight at a time
  typedef enum logic [1:0] {
    stateIdle,
    // aw/w handshake cycle
    stateWrite,
    // ar handshake cycle
    stateRead,
    // waiting on bReady or rReady
    stateAck
  } slaveState_t;

endpackage

`default_nettype wire

/* design/mdioRegPkg.sv */
// MDIO register map, control field positions and data types, imported by RTL and testbench
`default_nettype none

package mdioRegPkg;

  // ==============================
  // data types
  // ==============================

  // word index, byte address bits 7:2
  typedef logic [5:0] regIndex_t;
  // PHY address on the MDIO bus
  typedef logic [4:0] phyAddr_t;
  // register number inside a PHY
  typedef logic [4:0] phyRegNum_t;
  // contents of one PHY register
  typedef logic [15:0] mdioData_t;

  // ==============================
  // PHY mirrors (read-only)
  // ==============================

  // basic registers
  localparam regIndex_t phyCtrlIdx     = 6'h00;
  localparam regIndex_t phyStatIdx     = 6'h01;
  // extended registers
  localparam regIndex_t phyIdent1Idx   = 6'h02;
  localparam regIndex_t phyIdent2Idx   = 6'h03;
  localparam regIndex_t phyAnaIdx      = 6'h04;
  localparam regIndex_t phyAnlpIdx     = 6'h05;
  localparam regIndex_t phyAneIdx      = 6'h06;
  // vendor-specific registers
  localparam regIndex_t phyModeIdx     = 6'h11;
  localparam regIndex_t phySpecModeIdx = 6'h12;
  localparam regIndex_t phySymErrIdx   = 6'h1A;
  localparam regIndex_t phyIndcIdx     = 6'h1B;
  localparam regIndex_t phyIntrSrcIdx  = 6'h1D;
  localparam regIndex_t phyIntrMskIdx  = 6'h1E;
  localparam regIndex_t phySpecCtrlIdx = 6'h1F;

  localparam int phyMirrorCount = 14;

  // mirror slot to PHY register number
  localparam regIndex_t phyMirrorIdxTable [phyMirrorCount] = '{
    phyCtrlIdx, phyStatIdx, phyIdent1Idx, phyIdent2Idx, phyAnaIdx,
    phyAnlpIdx, phyAneIdx, phyModeIdx, phySpecModeIdx, phySymErrIdx,
    phyIndcIdx, phyIntrSrcIdx, phyIntrMskIdx, phySpecCtrlIdx
  };

  // ==============================
  // user registers (read/write)
  // ==============================

  localparam regIndex_t usrCtrlIdx  = 6'h20;
  localparam regIndex_t usrWriteIdx = 6'h21;

  // control register fields
  localparam int ctrlEnableBit  = 0;
  // 0 read, 1 write
  localparam int ctrlWriteBit   = 1;
  localparam int ctrlPhyAddrLsb = 2;
  localparam int ctrlRegNumLsb  = 7;

endpackage

`default_nettype wire

/* design/axiLiteSlave.sv */
// AXI4-Lite front end: channel handshakes, word-index decode and read-data merge for ethRegs
`timescale 1ns/1ps
`default_nettype none

module axiLiteSlave (
  input  wire logic                  axiClk,
  input  wire logic                  reset,

  // write address
  input  wire logic                  awValid,
  output logic                       awReady,
  input  wire axiLitePkg::axiAddr_t  awAddr,

  // write data
  input  wire logic                  wValid,
  output logic                       wReady,
  input  wire axiLitePkg::axiData_t  wData,

  // write response
  output logic                       bValid,
  input  wire logic                  bReady,
  output axiLitePkg::axiResp_t       bResp,

  // read address
  input  wire logic                  arValid,
  output logic                       arReady,
  input  wire axiLitePkg::axiAddr_t  arAddr,

  // read data
  output logic                       rValid,
  input  wire logic                  rReady,
  output axiLitePkg::axiData_t       rData,
  output axiLitePkg::axiResp_t       rResp,

  // register block side
  output logic                       regWrEn,
  output mdioRegPkg::regIndex_t      regWrIdx,
  output axiLitePkg::axiData_t       regWrData,
  output mdioRegPkg::regIndex_t      regRdIdx,
  input  wire axiLitePkg::axiData_t  usrRdData,
  input  wire axiLitePkg::axiData_t  phyRdData
);

  import axiLitePkg::*;
  import mdioRegPkg::*;

  slaveState_t state;

  // ==============================
  // handshake outputs
  // ==============================

  // readies last exactly one cycle, set by the state
  assign awReady = (state == stateWrite);
  assign wReady  = (state == stateWrite);
  assign arReady = (state == stateRead);

  // no error cases in this map
  assign bResp = respOkay;
  assign rResp = respOkay;

  // write strobe lines up with the aw/w handshake
  assign regWrEn   = (state == stateWrite);
  // master holds awAddr until awReady, so decode directly
  assign regWrIdx  = awAddr[7:2];
  assign regWrData = wData;

  // ==============================
  // transaction FSM
  // ==============================

  always_ff @(posedge axiClk) begin
    if (reset) begin
      state    <= stateIdle;
      bValid   <= 1'b0;
      rValid   <= 1'b0;
      regRdIdx <= '0;
    end else begin
      case (state)
        stateIdle: begin
          // write wins over a read in the same cycle
          if (awValid && wValid) begin
            state <= stateWrite;
          end else if (arValid) begin
            // word index of the read
            regRdIdx <= arAddr[7:2];
            state    <= stateRead;
          end
        end
        stateWrite: begin
          bValid <= 1'b1;
          state  <= stateAck;
        end
        stateRead: begin
          rValid <= 1'b1;
          state  <= stateAck;
        end
        stateAck: begin
          // hold response until taken
          if (bValid && bReady) begin
            bValid <= 1'b0;
            state  <= stateIdle;
          end
          if (rValid && rReady) begin
            rValid <= 1'b0;
            state  <= stateIdle;
          end
        end
        default: begin
          state <= stateIdle;
        end
      endcase
    end
  end

  // ==============================
  // read data
  // ==============================

  // each block drives zero unless it owns the index
  always_ff @(posedge axiClk) begin
    if (state == stateRead) begin
      rData <= usrRdData | phyRdData;
    end
  end

  // ==============================
  // checks
  // ==============================

  // only one response may be pending
  assert property (@(posedge axiClk) disable iff (reset) !(bValid && rValid));

  // every write goes through ack before the next handshake
  assert property (@(posedge axiClk) disable iff (reset) awReady |=> !awReady);

endmodule

`default_nettype wire

/* design/mdioUserRegs.sv */
// host-writable MDIO control and write-data registers, driving the MDIO request outputs
`timescale 1ns/1ps
`default_nettype none

module mdioUserRegs (
  input  wire logic                   axiClk,
  input  wire logic                   reset,

  // write port from the front end
  input  wire logic                   regWrEn,
  input  wire mdioRegPkg::regIndex_t  regWrIdx,
  input  wire axiLitePkg::axiData_t   regWrData,

  // read port
  input  wire mdioRegPkg::regIndex_t  regRdIdx,
  output axiLitePkg::axiData_t        usrRdData,

  // MDIO request
  output logic                        mdioEnable,
  output logic                        mdioWrite,
  output mdioRegPkg::phyAddr_t        mdioPhyAddr,
  output mdioRegPkg::phyRegNum_t      mdioRegNum,
  output mdioRegPkg::mdioData_t       mdioWrData
);

  import axiLitePkg::*;
  import mdioRegPkg::*;

  // full words are kept, upper bits read back as written
  axiData_t ctrlReg;
  axiData_t wrDataReg;

  // ==============================
  // register writes
  // ==============================

  always_ff @(posedge axiClk) begin
    if (reset) begin
      ctrlReg   <= '0;
      wrDataReg <= '0;
    end else if (regWrEn) begin
      // other indices are silently dropped
      if (regWrIdx == usrCtrlIdx) begin
        ctrlReg <= regWrData;
      end
      if (regWrIdx == usrWriteIdx) begin
        wrDataReg <= regWrData;
      end
    end
  end

  // ==============================
  // read mux
  // ==============================

  always_comb begin
    case (regRdIdx)
      usrCtrlIdx:  usrRdData = ctrlReg;
      usrWriteIdx: usrRdData = wrDataReg;
      // not ours, mirrors or unmapped
      default:     usrRdData = '0;
    endcase
  end

  // ==============================
  // MDIO request fields
  // ==============================

  assign mdioEnable  = ctrlReg[ctrlEnableBit];
  assign mdioWrite   = ctrlReg[ctrlWriteBit];
  assign mdioPhyAddr = ctrlReg[ctrlPhyAddrLsb +: $bits(phyAddr_t)];
  assign mdioRegNum  = ctrlReg[ctrlRegNumLsb +: $bits(phyRegNum_t)];
  // low half-word only, the PHY register width
  assign mdioWrData  = wrDataReg[$bits(mdioData_t)-1:0];

endmodule

`default_nettype wire

/* design/phyMirrorRegs.sv */
// read-only mirrors of the PHY registers, refreshed by results posted from the MDIO engine
`timescale 1ns/1ps
`default_nettype none

module phyMirrorRegs (
  input  wire logic                    axiClk,
  input  wire logic                    reset,

  // result strobe from the MDIO engine
  input  wire logic                    phyRegValid,
  input  wire mdioRegPkg::phyRegNum_t  phyRegNum,
  input  wire mdioRegPkg::mdioData_t   phyRegData,

  // read port
  input  wire mdioRegPkg::regIndex_t   regRdIdx,
  output axiLitePkg::axiData_t         phyRdData
);

  import axiLitePkg::*;
  import mdioRegPkg::*;

  // one slot per listed PHY register
  mdioData_t mirror [phyMirrorCount];

  // register number widened to the index type
  regIndex_t resultIdx;

  assign resultIdx = regIndex_t'(phyRegNum);

  // ==============================
  // mirror updates
  // ==============================

  always_ff @(posedge axiClk) begin
    if (reset) begin
      for (int i = 0; i < phyMirrorCount; i++) begin
        mirror[i] <= '0;
      end
    end else if (phyRegValid) begin
      // unlisted numbers match no slot and are dropped
      for (int i = 0; i < phyMirrorCount; i++) begin
        if (resultIdx == phyMirrorIdxTable[i]) begin
          mirror[i] <= phyRegData;
        end
      end
    end
  end

  // ==============================
  // read mux
  // ==============================

  always_comb begin
    phyRdData = '0;
    for (int i = 0; i < phyMirrorCount; i++) begin
      if (regRdIdx == phyMirrorIdxTable[i]) begin
        // zero-extend 16 -> 32
        phyRdData = axiData_t'(mirror[i]);
      end
    end
  end

  // ==============================
  // checks
  // ==============================

  // engine must post a defined number with each result
  assert property (@(posedge axiClk) disable iff (reset)
    phyRegValid |-> !$isunknown(phyRegNum));

endmodule

`default_nettype wire

/* design/ethRegs.sv */
// top level of the MDIO register slave: AXI4-Lite front end plus user and mirror register blocks
`timescale 1ns/1ps
`default_nettype none

module ethRegs (
  input  wire logic                    axiClk,
  input  wire logic                    reset,

  // AXI4-Lite write channels
  input  wire logic                    awValid,
  output logic                         awReady,
  input  wire axiLitePkg::axiAddr_t    awAddr,
  input  wire logic                    wValid,
  output logic                         wReady,
  input  wire axiLitePkg::axiData_t    wData,
  output logic                         bValid,
  input  wire logic                    bReady,
  output axiLitePkg::axiResp_t         bResp,

  // AXI4-Lite read channels
  input  wire logic                    arValid,
  output logic                         arReady,
  input  wire axiLitePkg::axiAddr_t    arAddr,
  output logic                         rValid,
  input  wire logic                    rReady,
  output axiLitePkg::axiData_t         rData,
  output axiLitePkg::axiResp_t         rResp,

  // MDIO request out
  output logic                         mdioEnable,
  output logic                         mdioWrite,
  output mdioRegPkg::phyAddr_t         mdioPhyAddr,
  output mdioRegPkg::phyRegNum_t       mdioRegNum,
  output mdioRegPkg::mdioData_t        mdioWrData,

  // MDIO results in
  input  wire logic                    phyRegValid,
  input  wire mdioRegPkg::phyRegNum_t  phyRegNum,
  input  wire mdioRegPkg::mdioData_t   phyRegData
);

  import axiLitePkg::*;
  import mdioRegPkg::*;

  // front end to register blocks
  logic      regWrEn;
  regIndex_t regWrIdx;
  axiData_t  regWrData;
  regIndex_t regRdIdx;
  axiData_t  usrRdData;
  axiData_t  phyRdData;

  // ==============================
  // bus front end
  // ==============================

  axiLiteSlave axiLiteSlave_inst (
    .axiClk    (axiClk),
    .reset     (reset),
    .awValid   (awValid),
    .awReady   (awReady),
    .awAddr    (awAddr),
    .wValid    (wValid),
    .wReady    (wReady),
    .wData     (wData),
    .bValid    (bValid),
    .bReady    (bReady),
    .bResp     (bResp),
    .arValid   (arValid),
    .arReady   (arReady),
    .arAddr    (arAddr),
    .rValid    (rValid),
    .rReady    (rReady),
    .rData     (rData),
    .rResp     (rResp),
    .regWrEn   (regWrEn),
    .regWrIdx  (regWrIdx),
    .regWrData (regWrData),
    .regRdIdx  (regRdIdx),
    .usrRdData (usrRdData),
    .phyRdData (phyRdData)
  );

  // ==============================
  // register blocks
  // ==============================

  // host side, 0x20 and 0x21
  mdioUserRegs mdioUserRegs_inst (
    .axiClk      (axiClk),
    .reset       (reset),
    .regWrEn     (regWrEn),
    .regWrIdx    (regWrIdx),
    .regWrData   (regWrData),
    .regRdIdx    (regRdIdx),
    .usrRdData   (usrRdData),
    .mdioEnable  (mdioEnable),
    .mdioWrite   (mdioWrite),
    .mdioPhyAddr (mdioPhyAddr),
    .mdioRegNum  (mdioRegNum),
    .mdioWrData  (mdioWrData)
  );

  // PHY side, no bus writes reach it
  phyMirrorRegs phyMirrorRegs_inst (
    .axiClk      (axiClk),
    .reset       (reset),
    .phyRegValid (phyRegValid),
    .phyRegNum   (phyRegNum),
    .phyRegData  (phyRegData),
    .regRdIdx    (regRdIdx),
    .phyRdData   (phyRdData)
  );

endmodule

`default_nettype wire

/* verif/ethRegsTb.sv */
// testbench for ethRegs that drives AXI4-Lite and MDIO traffic and checks it against a model
`timescale 1ns/1ps
`default_nettype none

module ethRegsTb;

  import axiLitePkg::*;
  import mdioRegPkg::*;

  // ==============================
  // run length
  // ==============================

  localparam int resetCycles = 4;
  localparam int userRounds  = 8;
  // reset sweep, user rounds, mirror strobe+read, unlisted strobes, ignored writes, final sweep
  localparam int txnCount   = 64 + 4 * userRounds + 2 * 14 + 18 + 17 + 64;
  localparam int cycleLimit = 40 * txnCount + resetCycles;

  // PHY register numbers that have a mirror
  localparam logic [5:0] mirrorNums [14] = '{
    6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06,
    6'h11, 6'h12, 6'h1A, 6'h1B, 6'h1D, 6'h1E, 6'h1F
  };

  logic       axiClk;
  logic       reset;
  logic       awValid;
  logic       awReady;
  axiAddr_t   awAddr;
  logic       wValid;
  logic       wReady;
  axiData_t   wData;
  logic       bValid;
  logic       bReady;
  axiResp_t   bResp;
  logic       arValid;
  logic       arReady;
  axiAddr_t   arAddr;
  logic       rValid;
  logic       rReady;
  axiData_t   rData;
  axiResp_t   rResp;
  logic       mdioEnable;
  logic       mdioWrite;
  phyAddr_t   mdioPhyAddr;
  phyRegNum_t mdioRegNum;
  mdioData_t  mdioWrData;
  logic       phyRegValid;
  phyRegNum_t phyRegNum;
  mdioData_t  phyRegData;

  // expected read value of every word index
  axiData_t model [64];
  int errorCount = 0;
  int cycleCount = 0;

  // expected MDIO request, sliced from the model
  logic       expEnable;
  logic       expWrite;
  logic [4:0] expPhyAddr;
  logic [4:0] expRegNum;
  logic [15:0] expWrData;

  assign expEnable  = model[usrCtrlIdx][0];
  assign expWrite   = model[usrCtrlIdx][1];
  assign expPhyAddr = model[usrCtrlIdx][6:2];
  assign expRegNum  = model[usrCtrlIdx][11:7];
  assign expWrData  = model[usrWriteIdx][15:0];

  ethRegs ethRegs_inst (.*);

  initial begin
    axiClk = 1'b0;
    forever #4 axiClk = ~axiClk;
  end

  // ==============================
  // helpers
  // ==============================

  function automatic bit isMirror(input logic [5:0] idx);
    for (int i = 0; i < 14; i++) begin
      if (mirrorNums[i] == idx) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic checkValue(input string name, input axiData_t expected,
                            input axiData_t actual);
    assert (actual === expected) else begin
      $display("FAILED: %s expected %h actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic writeReg(input regIndex_t idx, input axiData_t data);
    int delay;
    delay = $urandom % 5;
    awAddr  <= axiAddr_t'(idx) << 2;
    wData   <= data;
    awValid <= 1'b1;
    wValid  <= 1'b1;
    do begin
      @(posedge axiClk);
    end while (!(awReady && wReady));
    awValid <= 1'b0;
    wValid  <= 1'b0;
    // only the two user registers take bus writes
    if (idx == usrCtrlIdx || idx == usrWriteIdx) begin
      model[idx] = data;
    end
    do begin
      @(posedge axiClk);
    end while (!bValid);
    // random back-pressure on the response
    repeat (delay) @(posedge axiClk);
    bReady <= 1'b1;
    do begin
      @(posedge axiClk);
    end while (!(bValid && bReady));
    bReady <= 1'b0;
    checkValue("bResp", axiData_t'(2'b00), axiData_t'(bResp));
  endtask

  task automatic readReg(input regIndex_t idx);
    int delay;
    delay = $urandom % 5;
    arAddr  <= axiAddr_t'(idx) << 2;
    arValid <= 1'b1;
    do begin
      @(posedge axiClk);
    end while (!arReady);
    arValid <= 1'b0;
    do begin
      @(posedge axiClk);
    end while (!rValid);
    repeat (delay) @(posedge axiClk);
    rReady <= 1'b1;
    do begin
      @(posedge axiClk);
    end while (!(rValid && rReady));
    rReady <= 1'b0;
    checkValue($sformatf("rData[%h]", idx), model[idx], rData);
    checkValue("rResp", axiData_t'(2'b00), axiData_t'(rResp));
  endtask

  // one-cycle result strobe from the MDIO engine
  task automatic postResult(input logic [4:0] num, input mdioData_t data);
    phyRegValid <= 1'b1;
    phyRegNum   <= num;
    phyRegData  <= data;
    @(posedge axiClk);
    phyRegValid <= 1'b0;
    if (isMirror({1'b0, num})) begin
      model[num] = axiData_t'(data);
    end
  endtask

  task automatic sweepAll();
    for (int i = 0; i < 64; i++) begin
      readReg(regIndex_t'(i));
    end
  endtask

  // ==============================
  // concurrent checks
  // ==============================

  assert property (@(posedge axiClk) disable iff (reset) mdioEnable == expEnable)
    else begin
      $display("FAILED: mdioEnable expected %h actual %h", $sampled(expEnable),
               $sampled(mdioEnable));
      errorCount++;
    end
  assert property (@(posedge axiClk) disable iff (reset) mdioWrite == expWrite)
    else begin
      $display("FAILED: mdioWrite expected %h actual %h", $sampled(expWrite),
               $sampled(mdioWrite));
      errorCount++;
    end
  assert property (@(posedge axiClk) disable iff (reset) mdioPhyAddr == expPhyAddr)
    else begin
      $display("FAILED: mdioPhyAddr expected %h actual %h", $sampled(expPhyAddr),
               $sampled(mdioPhyAddr));
      errorCount++;
    end
  assert property (@(posedge axiClk) disable iff (reset) mdioRegNum == expRegNum)
    else begin
      $display("FAILED: mdioRegNum expected %h actual %h", $sampled(expRegNum),
               $sampled(mdioRegNum));
      errorCount++;
    end
  assert property (@(posedge axiClk) disable iff (reset) mdioWrData == expWrData)
    else begin
      $display("FAILED: mdioWrData expected %h actual %h", $sampled(expWrData),
               $sampled(mdioWrData));
      errorCount++;
    end

  // pending responses hold until taken
  assert property (@(posedge axiClk) disable iff (reset)
    bValid && !bReady |=> bValid && $stable(bResp))
    else begin
      $display("ERROR: write response dropped or changed while bReady was low");
      errorCount++;
    end
  assert property (@(posedge axiClk) disable iff (reset)
    rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
    else begin
      $display("ERROR: read response dropped or changed while rReady was low");
      errorCount++;
    end
  // no address handshake while a response waits
  assert property (@(posedge axiClk) disable iff (reset)
    (bValid || rValid) |-> !(awReady || wReady || arReady))
    else begin
      $display("ERROR: a ready went high while a response was still pending");
      errorCount++;
    end

  // ==============================
  // timeout
  // ==============================

  always @(posedge axiClk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("ERROR: run did not finish within %0d cycles", cycleLimit);
      $display("errors: %0d", errorCount + 1);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ==============================
  // stimulus
  // ==============================

  initial begin
    void'($urandom(32'h458f));
    reset       = 1'b1;
    awValid     = 1'b0;
    awAddr      = '0;
    wValid      = 1'b0;
    wData       = '0;
    bReady      = 1'b0;
    arValid     = 1'b0;
    arAddr      = '0;
    rReady      = 1'b0;
    phyRegValid = 1'b0;
    phyRegNum   = '0;
    phyRegData  = '0;
    for (int i = 0; i < 64; i++) begin
      model[i] = '0;
    end
    repeat (resetCycles) @(posedge axiClk);
    reset <= 1'b0;
    @(posedge axiClk);

    // outputs quiet right after reset
    checkValue("awReady", '0, axiData_t'(awReady));
    checkValue("wReady", '0, axiData_t'(wReady));
    checkValue("arReady", '0, axiData_t'(arReady));
    checkValue("bValid", '0, axiData_t'(bValid));
    checkValue("rValid", '0, axiData_t'(rValid));
    checkValue("mdioEnable", '0, axiData_t'(mdioEnable));
    sweepAll();

    // user registers and MDIO request fields
    for (int r = 0; r < userRounds; r++) begin
      writeReg(usrCtrlIdx, $urandom);
      writeReg(usrWriteIdx, $urandom);
      readReg(usrCtrlIdx);
      readReg(usrWriteIdx);
    end

    // every mirror, then every unlisted number
    for (int i = 0; i < 14; i++) begin
      postResult(mirrorNums[i][4:0], mdioData_t'($urandom));
      readReg(mirrorNums[i]);
    end
    for (int n = 0; n < 32; n++) begin
      if (!isMirror(6'(n))) begin
        postResult(5'(n), mdioData_t'($urandom));
      end
    end

    // writes that must change nothing
    for (int i = 0; i < 14; i++) begin
      writeReg(mirrorNums[i], $urandom);
    end
    writeReg(6'h07, $urandom);
    writeReg(6'h30, $urandom);
    writeReg(6'h3F, $urandom);
    sweepAll();

    repeat (2) @(posedge axiClk);
    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/axiLitePkg.sv
design/mdioRegPkg.sv
design/axiLiteSlave.sv
design/mdioUserRegs.sv
design/phyMirrorRegs.sv
design/ethRegs.sv
verif/ethRegsTb.sv

/* Bender.yml */
package:
  name: eth_regs

sources:
  # packages first, then the RTL tree bottom-up
  - files:
      - design/axiLitePkg.sv
      - design/mdioRegPkg.sv
      - design/axiLiteSlave.sv
      - design/mdioUserRegs.sv
      - design/phyMirrorRegs.sv
      - design/ethRegs.sv
  - target: test
    files:
      - verif/ethRegsTb.sv
